// File: src/cpu_types_pkg.sv
// shared widths and vector types of the 6809 bus and its E/Q timing
// the phase count runs 0..3 per CPU cycle, E on 0 and Q on 2
// misses saturate at MISS_MAX, lost time beyond that is not repaid

package cpu_types_pkg;

    typedef logic [15:0] addr_t;   // CPU address
    typedef logic [7:0]  byte_t;   // data byte
    typedef logic [1:0]  phase_t;  // quadrature phase count
    typedef logic [3:0]  miss_t;   // missed phase count

    // local work RAM, 2**RAM_AW bytes
    localparam int RAM_AW = 10;

    // saturation value of the missed phase count
    localparam miss_t MISS_MAX = 4'd15;

    // phase slots where the CPU clock enables fire
    localparam phase_t PH_E = 2'd0;
    localparam phase_t PH_Q = 2'd2;

endpackage

// File: src/sys_ctrl_pkg.sv
// configuration register map and the structs that carry the CPU bus
// and configuration writes between the blocks
// CFG_STAT is read-only, writes to it are dropped

package sys_ctrl_pkg;

    // one-bit register index
    typedef logic cfg_addr_t;

    localparam cfg_addr_t CFG_CTRL = 1'b0;
    localparam cfg_addr_t CFG_STAT = 1'b1;

    // bit positions inside CFG_CTRL
    localparam int CTRL_RECOVERY_BIT = 0;
    localparam int CTRL_DECRYPT_BIT  = 1;

    // a single configuration write, acted on while we is high
    typedef struct packed {
        logic                  we;
        cfg_addr_t             addr;
        cpu_types_pkg::byte_t  data;
    } cfg_wr_t;

    // enables as seen by the timing and memory logic
    typedef struct packed {
        logic recovery_en;  // repay lost phases after a stall
        logic decrypt_en;   // Konami-1 opcode decryption
    } cfg_t;

    // CPU bus as driven by the core
    typedef struct packed {
        cpu_types_pkg::addr_t  addr;
        logic                  rnw;   // 1 = read
        logic                  op;    // opcode fetch
        logic                  avma;  // advance VMA, valid next cycle
        cpu_types_pkg::byte_t  dout;  // write data
    } cpu_bus_t;

endpackage

// File: src/bus_wait_gate.sv
// stall condition for the CPU clock enables
// gate is combinational so a stall holds the very cen it coincides with
// rom_ok is only looked at while rom_cs is high

module bus_wait_gate (
    input  logic clk,
    input  logic rstn,
    input  logic dev_busy,   // shared bus owned by another device
    input  logic rom_cs,
    input  logic rom_ok,
    output logic gate
);

    logic stall;

    // slow ROM data or a bus owner holds the CPU off
    assign stall = dev_busy | (rom_cs & ~rom_ok);
    assign gate  = ~stall;

endmodule

// File: src/cen_quad_gen.sv
// E/Q quadrature enables out of the fast cen strobe, one CPU cycle per 4 cen
// cen must not be high on two clocks in a row
// phases stalled while gate is low are counted and, with recovery_en,
// repaid by skipping the odd phase until the count is back at zero

module cen_quad_gen (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 cen,
    input  logic                 gate,
    input  logic                 recovery_en,
    output logic                 cen_e,
    output logic                 cen_q,
    output cpu_types_pkg::miss_t misses
);

    cpu_types_pkg::phase_t phase;
    logic                  eq;       // E or Q fired on this cen
    logic                  last_eq;  // E or Q fired on the previous cen
    logic                  catchup;

    // both enables are combinational with cen, no extra latency
    assign cen_e = cen & gate & (phase == cpu_types_pkg::PH_E);
    assign cen_q = cen & gate & (phase == cpu_types_pkg::PH_Q);
    assign eq    = cen_e | cen_q;

    assign catchup = recovery_en && (misses != '0);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            phase   <= cpu_types_pkg::PH_E;
            misses  <= '0;
            last_eq <= 1'b0;
        end else if (cen) begin
            last_eq <= eq;
            if (gate) begin
                if (catchup) begin
                    // jump straight to the next E or Q slot
                    phase  <= {~phase[1], 1'b0};
                    misses <= misses - 4'd1;
                end else begin
                    phase <= phase + 2'd1;
                end
            end else if (phase[0]) begin
                // half phase invisible to the CPU, let it pass
                phase <= phase + 2'd1;
            end else if (!last_eq && misses != cpu_types_pkg::MISS_MAX) begin
                misses <= misses + 4'd1;  // phase held, count it
            end
        end
    end

endmodule

// File: src/cpu_mem_port.sv
// CPU side memory port: work RAM, VMA register and Konami-1 decryption
// RAM is read-first, ram_dout holds the old byte on a write cycle
// the address is not range checked, upper bits alias onto the RAM

module cpu_mem_port (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    cen_e,
    input  logic                    cen_q,
    input  logic                    ram_cs,
    input  sys_ctrl_pkg::cpu_bus_t  cpu_bus,
    input  cpu_types_pkg::byte_t    cpu_din,
    input  logic                    decrypt_en,
    output cpu_types_pkg::byte_t    ram_dout,
    output cpu_types_pkg::byte_t    cpu_din_dec,
    output logic                    vma
);

    localparam int RAM_SIZE = 2 ** cpu_types_pkg::RAM_AW;

    cpu_types_pkg::byte_t                mem [RAM_SIZE];
    logic [cpu_types_pkg::RAM_AW-1:0]    ram_addr;
    logic                                ram_we;
    cpu_types_pkg::byte_t                dec_mask;

    assign ram_addr = cpu_bus.addr[cpu_types_pkg::RAM_AW-1:0];
    assign ram_we   = ram_cs & ~cpu_bus.rnw;

    // data moves on Q, when the 6809 address is stable
    always_ff @(posedge clk) begin
        if (cen_q) begin
            ram_dout <= mem[ram_addr];
            if (ram_we) begin
                mem[ram_addr] <= cpu_bus.dout;
            end
        end
    end

    // vma follows avma one cycle later, sampled on E
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vma <= 1'b1;
        end else if (cen_e) begin
            vma <= cpu_bus.avma;
        end
    end

    // odd bits flipped by address bits 1 and 3, even bits untouched
    assign dec_mask = {cpu_bus.addr[1], 1'b0, ~cpu_bus.addr[1], 1'b0,
                       cpu_bus.addr[3], 1'b0, ~cpu_bus.addr[3], 1'b0};

    // only opcode fetches are scrambled
    assign cpu_din_dec = (decrypt_en && cpu_bus.op) ? (cpu_din ^ dec_mask) : cpu_din;

endmodule

// File: src/sys_cfg_regs.sv
// two byte-wide configuration registers
// CFG_CTRL holds the run-time enables, CFG_STAT shows the missed phase count
// writes land on the next clock, readback is combinational

module sys_cfg_regs (
    input  logic                    clk,
    input  logic                    rstn,
    input  sys_ctrl_pkg::cfg_wr_t   cfg_wr,
    input  sys_ctrl_pkg::cfg_addr_t cfg_raddr,
    input  cpu_types_pkg::miss_t    misses,
    output sys_ctrl_pkg::cfg_t      cfg,
    output cpu_types_pkg::byte_t    cfg_rdata
);

    logic ctrl_wr;

    assign ctrl_wr = cfg_wr.we && (cfg_wr.addr == sys_ctrl_pkg::CFG_CTRL);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cfg <= '0;  // recovery and decryption off
        end else if (ctrl_wr) begin
            cfg.recovery_en <= cfg_wr.data[sys_ctrl_pkg::CTRL_RECOVERY_BIT];
            cfg.decrypt_en  <= cfg_wr.data[sys_ctrl_pkg::CTRL_DECRYPT_BIT];
        end
    end

    always_comb begin
        cfg_rdata = '0;
        case (cfg_raddr)
            sys_ctrl_pkg::CFG_CTRL: begin
                cfg_rdata[sys_ctrl_pkg::CTRL_RECOVERY_BIT] = cfg.recovery_en;
                cfg_rdata[sys_ctrl_pkg::CTRL_DECRYPT_BIT]  = cfg.decrypt_en;
            end
            sys_ctrl_pkg::CFG_STAT: begin
                cfg_rdata[3:0] = misses;  // upper nibble reads zero
            end
            default: cfg_rdata = '0;
        endcase
    end

endmodule

// File: src/sys6809_bus.sv
// bus and timing support for a 6809-class core, the core sits outside
// cen is the CPU 4x enable and must never be high two clocks in a row
// cpu_cen is the Q enable, for logic clocked once per CPU cycle

module sys6809_bus (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    cen,
    input  logic                    dev_busy,
    input  logic                    rom_cs,
    input  logic                    rom_ok,
    input  logic                    ram_cs,
    input  sys_ctrl_pkg::cpu_bus_t  cpu_bus,
    input  cpu_types_pkg::byte_t    cpu_din,
    input  sys_ctrl_pkg::cfg_wr_t   cfg_wr,
    input  sys_ctrl_pkg::cfg_addr_t cfg_raddr,
    output logic                    cen_e,
    output logic                    cen_q,
    output logic                    cpu_cen,
    output logic                    vma,
    output cpu_types_pkg::byte_t    ram_dout,
    output cpu_types_pkg::byte_t    cpu_din_dec,
    output cpu_types_pkg::byte_t    cfg_rdata
);

    logic                 gate;
    sys_ctrl_pkg::cfg_t   cfg;
    cpu_types_pkg::miss_t misses;

    assign cpu_cen = cen_q;

    bus_wait_gate u_gate (
        .clk        (clk),
        .rstn       (rstn),
        .dev_busy   (dev_busy),
        .rom_cs     (rom_cs),
        .rom_ok     (rom_ok),
        .gate       (gate)
    );

    cen_quad_gen u_quad (
        .clk         (clk),
        .rstn        (rstn),
        .cen         (cen),
        .gate        (gate),
        .recovery_en (cfg.recovery_en),
        .cen_e       (cen_e),
        .cen_q       (cen_q),
        .misses      (misses)
    );

    cpu_mem_port u_mem (
        .clk         (clk),
        .rstn        (rstn),
        .cen_e       (cen_e),
        .cen_q       (cen_q),
        .ram_cs      (ram_cs),
        .cpu_bus     (cpu_bus),
        .cpu_din     (cpu_din),
        .decrypt_en  (cfg.decrypt_en),
        .ram_dout    (ram_dout),
        .cpu_din_dec (cpu_din_dec),
        .vma         (vma)
    );

    sys_cfg_regs u_cfg (
        .clk         (clk),
        .rstn        (rstn),
        .cfg_wr      (cfg_wr),
        .cfg_raddr   (cfg_raddr),
        .misses      (misses),
        .cfg         (cfg),
        .cfg_rdata   (cfg_rdata)
    );

endmodule

// File: testbench/sys6809_checker.sv
// assertions on the E/Q enables and the missed phase count
// bound into every cen_quad_gen and sampled on the rising edge
// E and Q alternate and the first enable after reset is E

module sys6809_checker (
    input logic                 clk,
    input logic                 rstn,
    input logic                 cen,
    input logic                 gate,
    input logic                 cen_e,
    input logic                 cen_q,
    input cpu_types_pkg::miss_t misses
);
    timeunit 1ns;
    timeprecision 100ps;

    logic last_e;  // most recent enable was E

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            last_e <= 1'b0;
        end else if (cen_e) begin
            last_e <= 1'b1;
        end else if (cen_q) begin
            last_e <= 1'b0;
        end
    end

    a_e_after_q: assert property (@(posedge clk) disable iff (!rstn) cen_e |-> !last_e)
        else $error("two E enables without a Q between them");

    a_q_after_e: assert property (@(posedge clk) disable iff (!rstn) cen_q |-> last_e)
        else $error("two Q enables without an E between them");

    // the count only climbs on a stalled cen
    a_miss_rise: assert property (@(posedge clk) disable iff (!rstn)
        !(cen && !gate) |=> !(misses > $past(misses)))
        else $error("missed phase count rose without a stalled cen");

    // and is only repaid on a cen that gets through
    a_miss_fall: assert property (@(posedge clk) disable iff (!rstn)
        !(cen && gate) |=> !(misses < $past(misses)))
        else $error("missed phase count fell without a running cen");

endmodule

bind cen_quad_gen sys6809_checker chk_i (
    .clk    (clk),
    .rstn   (rstn),
    .cen    (cen),
    .gate   (gate),
    .cen_e  (cen_e),
    .cen_q  (cen_q),
    .misses (misses)
);

// File: testbench/tb_sys6809_bus.sv
// testbench for sys6809_bus, plays the CPU and the bus owners
// inputs change 1 ns after the rising edge, outputs are compared on the falling edge
// RAM bytes never written are not checked, their content is unknown

module tb_sys6809_bus;
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        cpu_types_pkg::phase_t phase;
        cpu_types_pkg::miss_t  misses;
        logic                  last_eq;  // E or Q on the previous cen
    } quad_state_t;

    // reset, test segments and config writes, in clocks
    localparam int TOTAL_CYCLES = 3 + 40 + 200 + 50 + 100 + 1 + 50 + 60 + 150
                                + 200 + 1 + 1 + 150 + 1 + 80 + 4;

    logic                    clk;
    logic                    rstn;
    logic                    cen;
    logic                    dev_busy;
    logic                    rom_cs;
    logic                    rom_ok;
    logic                    ram_cs;
    sys_ctrl_pkg::cpu_bus_t  cpu_bus;
    cpu_types_pkg::byte_t    cpu_din;
    sys_ctrl_pkg::cfg_wr_t   cfg_wr;
    sys_ctrl_pkg::cfg_addr_t cfg_raddr;
    logic                    cen_e;
    logic                    cen_q;
    logic                    cpu_cen;
    logic                    vma;
    cpu_types_pkg::byte_t    ram_dout;
    cpu_types_pkg::byte_t    cpu_din_dec;
    cpu_types_pkg::byte_t    cfg_rdata;

    string test_name = "reset";
    int    errors    = 0;
    int    checks    = 0;

    // reference model state
    quad_state_t          m_quad;
    logic                 m_rec;
    logic                 m_dec;
    logic                 m_vma;
    cpu_types_pkg::byte_t ram_model [int];
    cpu_types_pkg::byte_t exp_ram;
    logic                 exp_ram_ok = 1'b0;

    sys6809_bus sys6809_bus_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // one cen worth of the phase rule
    function automatic quad_state_t model_phase_step(quad_state_t s, logic gate, logic rec);
        quad_state_t n;
        n = s;
        n.last_eq = gate && (s.phase == 2'd0 || s.phase == 2'd2);
        if (gate) begin
            if (rec && s.misses != 4'd0) begin
                n.phase  = (s.phase < 2'd2) ? 2'd2 : 2'd0;  // skip to the next slot
                n.misses = s.misses - 4'd1;
            end else begin
                n.phase = s.phase + 2'd1;
            end
        end else if (s.phase == 2'd1 || s.phase == 2'd3) begin
            n.phase = s.phase + 2'd1;
        end else if (!s.last_eq && s.misses != 4'd15) begin
            n.misses = s.misses + 4'd1;
        end
        return n;
    endfunction

    function automatic cpu_types_pkg::byte_t model_decrypt(cpu_types_pkg::byte_t din,
                                                          cpu_types_pkg::addr_t addr,
                                                          logic en);
        cpu_types_pkg::byte_t d;
        d = din;
        if (en) begin
            d[7] = din[7] ^ addr[1];
            d[5] = din[5] ^ ~addr[1];
            d[3] = din[3] ^ addr[3];
            d[1] = din[1] ^ ~addr[3];
        end
        return d;
    endfunction

    task automatic check_bit(input string what, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic check_byte(input string what, input cpu_types_pkg::byte_t exp,
                              input cpu_types_pkg::byte_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_miss(input string what, input cpu_types_pkg::miss_t exp,
                              input cpu_types_pkg::miss_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s %s: expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    // compare, then advance the model to what the next rising edge does
    always @(negedge clk) begin : compare
        logic                 gate_m;
        logic                 exp_e;
        logic                 exp_q;
        cpu_types_pkg::byte_t exp_cfg;
        int                   key;
        if (!rstn) begin
            m_quad = '0;
            m_rec  = 1'b0;
            m_dec  = 1'b0;
            m_vma  = 1'b1;
        end else begin
            gate_m = !(dev_busy || (rom_cs && !rom_ok));
            exp_e  = cen && gate_m && (m_quad.phase == 2'd0);
            exp_q  = cen && gate_m && (m_quad.phase == 2'd2);
            check_bit("cen_e", exp_e, cen_e);
            check_bit("cen_q", exp_q, cen_q);
            check_bit("cpu_cen", exp_q, cpu_cen);
            check_bit("vma", m_vma, vma);
            check_byte("cpu_din_dec", model_decrypt(cpu_din, cpu_bus.addr, m_dec && cpu_bus.op),
                       cpu_din_dec);
            if (cfg_raddr == sys_ctrl_pkg::CFG_STAT) begin
                check_miss("cfg_stat", m_quad.misses, cfg_rdata[3:0]);
            end else begin
                exp_cfg = '0;
                exp_cfg[sys_ctrl_pkg::CTRL_RECOVERY_BIT] = m_rec;
                exp_cfg[sys_ctrl_pkg::CTRL_DECRYPT_BIT]  = m_dec;
                check_byte("cfg_ctrl", exp_cfg, cfg_rdata);
            end
            if (exp_ram_ok) check_byte("ram_dout", exp_ram, ram_dout);

            if (cen) m_quad = model_phase_step(m_quad, gate_m, m_rec);
            if (exp_e) m_vma = cpu_bus.avma;
            if (exp_q) begin
                key        = int'(cpu_bus.addr[cpu_types_pkg::RAM_AW-1:0]);
                exp_ram_ok = ram_model.exists(key);
                if (exp_ram_ok) exp_ram = ram_model[key];  // old byte, read first
                if (ram_cs && !cpu_bus.rnw) ram_model[key] = cpu_bus.dout;
            end
            if (cfg_wr.we && cfg_wr.addr == sys_ctrl_pkg::CFG_CTRL) begin
                m_rec = cfg_wr.data[0];
                m_dec = cfg_wr.data[1];
            end
        end
    end

    // one clock of random CPU traffic, cen toggles so it pulses every second clock
    task automatic drive_cycle(input int busy_pct, input int rom_pct);
        logic [31:0] r;
        @(posedge clk);
        #1;
        r            = $urandom;
        cen          = ~cen;
        dev_busy     = ($urandom % 100) < busy_pct;
        rom_cs       = ($urandom % 100) < rom_pct;
        rom_ok       = r[0];
        ram_cs       = r[2:1] != 2'b00;
        cpu_bus.rnw  = r[3];
        cpu_bus.op   = r[4];
        cpu_bus.avma = r[5];
        cpu_bus.dout = r[15:8];
        cpu_bus.addr = r[31:16] & 16'hF30F;  // small RAM window, upper bits alias
        r            = $urandom;
        cpu_din      = r[7:0];
        cfg_raddr    = r[8];
        cfg_wr       = '0;
    endtask

    task automatic run_cycles(input string name, input int n, input int busy_pct,
                              input int rom_pct);
        test_name = name;
        repeat (n) drive_cycle(busy_pct, rom_pct);
    endtask

    task automatic write_cfg(input sys_ctrl_pkg::cfg_addr_t addr,
                             input cpu_types_pkg::byte_t data);
        drive_cycle(0, 0);
        cfg_wr.we   = 1'b1;
        cfg_wr.addr = addr;
        cfg_wr.data = data;
    endtask

    initial begin
        void'($urandom(32'h22145165));
        rstn      = 1'b0;
        cen       = 1'b0;
        dev_busy  = 1'b0;
        rom_cs    = 1'b0;
        rom_ok    = 1'b0;
        ram_cs    = 1'b0;
        cpu_bus   = '0;
        cpu_din   = '0;
        cfg_wr    = '0;
        cfg_raddr = sys_ctrl_pkg::CFG_CTRL;
        repeat (3) @(posedge clk);
        #1 rstn = 1'b1;

        run_cycles("no_stall", 40, 0, 0);
        run_cycles("stall", 200, 25, 30);
        run_cycles("stall_sat", 50, 100, 0);   // long enough to hit 15
        run_cycles("stall_mix", 100, 20, 20);

        test_name = "recovery_cfg";
        write_cfg(sys_ctrl_pkg::CFG_CTRL, 8'h01);
        run_cycles("recovery_stall", 50, 100, 0);
        run_cycles("recovery_catchup", 60, 0, 0);
        run_cycles("recovery_mix", 150, 20, 20);
        run_cycles("ram", 200, 0, 0);

        test_name = "cfg_write";
        write_cfg(sys_ctrl_pkg::CFG_STAT, 8'hFF);  // read-only, dropped
        write_cfg(sys_ctrl_pkg::CFG_CTRL, 8'h03);
        run_cycles("decrypt_on", 150, 10, 10);
        write_cfg(sys_ctrl_pkg::CFG_CTRL, 8'h00);
        run_cycles("decrypt_off", 80, 10, 10);
        run_cycles("idle", 4, 0, 0);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(TOTAL_CYCLES * 10 + 500);
        $display("Timeout: test sequence did not finish within %0d cycles", TOTAL_CYCLES);
        $display("Checks failed");
        $finish;
    end

endmodule

// File: list.f
src/cpu_types_pkg.sv
src/sys_ctrl_pkg.sv
src/bus_wait_gate.sv
src/cen_quad_gen.sv
src/cpu_mem_port.sv
src/sys_cfg_regs.sv
src/sys6809_bus.sv
testbench/sys6809_checker.sv
testbench/tb_sys6809_bus.sv

// File: run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_sys6809_bus -f list.f > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/Vtb_sys6809_bus > sim.log 2>&1 \
    || echo "simulator exited with an error status" >> sim.log
cat sim.log

grep -q "Checks failed" sim.log && { echo "RESULT: FAIL"; exit 1; }
grep -q "All checks passed" sim.log && echo "RESULT: PASS" \
    || { echo "RESULT: FAIL (no result line)"; exit 1; }
